// ==== design/cpuPkg.sv ====
package cpuPkg;

	// condition flag positions in the PSR
	localparam int NUM_FLAGS = 5;
	localparam int FLAG_C = 0; // carry, or borrow on subtract
	localparam int FLAG_F = 1; // signed overflow
	localparam int FLAG_L = 2; // unsigned less, from CMP
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 4; // signed less, from CMP

	// primary opcode, instr[15:12]
	typedef enum logic [3:0] {
		OP_RTYPE = 4'd0,
		OP_ANDI  = 4'd1,
		OP_ORI   = 4'd2,
		OP_XORI  = 4'd3,
		OP_ADDI  = 4'd5,
		OP_ADDCI = 4'd7,
		OP_SHIFT = 4'd8,
		OP_SUBI  = 4'd9,
		OP_CMPI  = 4'd11,
		OP_MOVI  = 4'd13,
		OP_LUI   = 4'd15
	} opcodeT;

	// extended opcode, instr[7:4], register form
	typedef enum logic [3:0] {
		EXT_AND  = 4'd1,
		EXT_OR   = 4'd2,
		EXT_XOR  = 4'd3,
		EXT_ADD  = 4'd5,
		EXT_ADDC = 4'd7,
		EXT_SUB  = 4'd9,
		EXT_CMP  = 4'd11,
		EXT_MOV  = 4'd13,
		EXT_NOT  = 4'd15
	} extOpT;

	// shift form uses the same field, some codes overlap the register form
	localparam extOpT EXT_LSH  = extOpT'(4'd0);
	localparam extOpT EXT_RSH  = extOpT'(4'd2);
	localparam extOpT EXT_ARSH = extOpT'(4'd7);
	localparam extOpT EXT_ALSH = extOpT'(4'd8);

	// internal ALU operation
	typedef enum logic [3:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ADD,
		ALU_ADDC,
		ALU_SUB,
		ALU_CMP,
		ALU_MOV,
		ALU_NOT,
		ALU_LSH,
		ALU_RSH,
		ALU_ALSH,
		ALU_ARSH,
		ALU_LUI
	} aluOpT;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu #(
	parameter int WIDTH = 16
) (
	input cpuPkg::aluOpT op,
	input logic [WIDTH-1:0] a, // destination operand
	input logic [WIDTH-1:0] b, // source or immediate
	input logic cIn,
	output logic [WIDTH-1:0] y,
	output logic [cpuPkg::NUM_FLAGS-1:0] condFlags
);
	import cpuPkg::*;

	logic carryIn;
	logic [WIDTH:0] addSum;
	logic [WIDTH:0] subDiff; // top bit is the borrow
	logic addOvf;
	logic subOvf;
	logic equal;
	logic [3:0] shAmt;

	assign carryIn = (op == ALU_ADDC) ? cIn : 1'b0;
	assign addSum = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, carryIn};
	assign subDiff = {1'b0, a} - {1'b0, b};

	// overflow when the sign of the result disagrees with the operands
	assign addOvf = (a[WIDTH-1] == b[WIDTH-1]) && (addSum[WIDTH-1] != a[WIDTH-1]);
	assign subOvf = (a[WIDTH-1] != b[WIDTH-1]) && (subDiff[WIDTH-1] != a[WIDTH-1]);

	assign equal = (subDiff[WIDTH-1:0] == '0);
	assign shAmt = b[3:0];

	always_comb begin
		y = '0;
		condFlags = '0;
		case (op)
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			ALU_ADD, ALU_ADDC: begin
				y = addSum[WIDTH-1:0];
				condFlags[FLAG_C] = addSum[WIDTH];
				condFlags[FLAG_F] = addOvf;
			end
			ALU_SUB: begin
				y = subDiff[WIDTH-1:0];
				condFlags[FLAG_C] = subDiff[WIDTH];
				condFlags[FLAG_F] = subOvf;
			end
			ALU_CMP: begin
				y = subDiff[WIDTH-1:0]; // not written back
				// src below dst means no borrow and not equal
				condFlags[FLAG_L] = !subDiff[WIDTH] && !equal;
				condFlags[FLAG_N] = !(subDiff[WIDTH-1] ^ subOvf) && !equal;
			end
			ALU_MOV: y = b;
			ALU_NOT: y = ~b;
			ALU_LSH, ALU_ALSH: y = a << shAmt;
			ALU_RSH: y = a >> shAmt;
			ALU_ARSH: y = $signed(a) >>> shAmt; // sign bit replicated
			ALU_LUI: y = {b[7:0], a[WIDTH-9:0]};
			default: y = '0;
		endcase

		// same zero test for every op, CMP difference is zero on equal
		condFlags[FLAG_Z] = (y == '0);
	end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/1ps

module registerFile #(
	parameter int WIDTH = 16,
	parameter int NUMREGS = 16
) (
	input logic clk,
	input logic rst,
	input logic writeEn,
	input logic [WIDTH-1:0] writeData,
	input logic [$clog2(NUMREGS)-1:0] srcAddr,
	input logic [$clog2(NUMREGS)-1:0] dstAddr, // also the write address
	output logic [WIDTH-1:0] readData1,
	output logic [WIDTH-1:0] readData2
);

	logic [WIDTH-1:0] regs [NUMREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUMREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[dstAddr] <= writeData;
		end
	end

	// async read, write only visible after the edge
	assign readData1 = regs[srcAddr];
	assign readData2 = regs[dstAddr];

	// address field can exceed the array when NUMREGS is not a power of two
	wrAddrInRange: assert property (
		@(posedge clk) disable iff (rst)
		writeEn |-> (dstAddr < NUMREGS)
	);

endmodule

// ==== design/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode #(
	parameter int WIDTH = 16,
	parameter int NUMREGS = 16
) (
	input logic [15:0] instr,
	output cpuPkg::aluOpT aluOp,
	output logic [$clog2(NUMREGS)-1:0] srcAddr,
	output logic [$clog2(NUMREGS)-1:0] dstAddr,
	output logic [WIDTH-1:0] immValue,
	output logic useImm,
	output logic writeBack
);
	import cpuPkg::*;

	opcodeT opcode;
	extOpT extOp;
	logic zeroExt; // logic immediates are unsigned

	assign opcode = opcodeT'(instr[15:12]);
	assign extOp = extOpT'(instr[7:4]);
	assign dstAddr = instr[8 +: $clog2(NUMREGS)];
	assign srcAddr = instr[0 +: $clog2(NUMREGS)];

	assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
	assign immValue = {{(WIDTH-8){instr[7] & !zeroExt}}, instr[7:0]};

	always_comb begin
		aluOp = ALU_AND;
		useImm = 1'b1;
		writeBack = 1'b1;
		case (opcode)
			OP_RTYPE: begin
				useImm = 1'b0;
				case (extOp)
					EXT_AND: aluOp = ALU_AND;
					EXT_OR: aluOp = ALU_OR;
					EXT_XOR: aluOp = ALU_XOR;
					EXT_ADD: aluOp = ALU_ADD;
					EXT_ADDC: aluOp = ALU_ADDC;
					EXT_SUB: aluOp = ALU_SUB;
					EXT_CMP: begin
						aluOp = ALU_CMP;
						writeBack = 1'b0;
					end
					EXT_MOV: aluOp = ALU_MOV;
					EXT_NOT: aluOp = ALU_NOT;
					default: writeBack = 1'b0;
				endcase
			end
			OP_SHIFT: begin
				useImm = 1'b0; // amount comes from the source register
				case (extOp)
					EXT_LSH: aluOp = ALU_LSH;
					EXT_RSH: aluOp = ALU_RSH;
					EXT_ALSH: aluOp = ALU_ALSH;
					EXT_ARSH: aluOp = ALU_ARSH;
					default: writeBack = 1'b0;
				endcase
			end
			OP_ANDI: aluOp = ALU_AND;
			OP_ORI: aluOp = ALU_OR;
			OP_XORI: aluOp = ALU_XOR;
			OP_ADDI: aluOp = ALU_ADD;
			OP_ADDCI: aluOp = ALU_ADDC;
			OP_SUBI: aluOp = ALU_SUB;
			OP_CMPI: begin
				aluOp = ALU_CMP;
				writeBack = 1'b0;
			end
			OP_MOVI: aluOp = ALU_MOV;
			OP_LUI: aluOp = ALU_LUI;
			default: writeBack = 1'b0; // unused opcodes
		endcase
	end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/1ps

module executeStage #(
	parameter int WIDTH = 16,
	parameter int NUMREGS = 16
) (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input cpuPkg::aluOpT aluOp,
	input logic [WIDTH-1:0] opA,
	input logic [WIDTH-1:0] opB,
	input logic [WIDTH-1:0] immValue,
	input logic useImm,
	input logic writeBack,
	input logic [$clog2(NUMREGS)-1:0] dstAddr,
	output logic [WIDTH-1:0] aluResult,
	output logic wrEn,
	output logic resultValid,
	output logic [WIDTH-1:0] result,
	output logic [cpuPkg::NUM_FLAGS-1:0] flags,
	output logic [$clog2(NUMREGS)-1:0] resultDst
);
	import cpuPkg::*;

	logic [WIDTH-1:0] operandB;
	logic [NUM_FLAGS-1:0] aluFlags;
	logic [NUM_FLAGS-1:0] psr;

	assign operandB = useImm ? immValue : opB;

	alu #(.WIDTH(WIDTH)) aluUnit (
		.op(aluOp),
		.a(opA),
		.b(operandB),
		.cIn(psr[FLAG_C]), // ADDC carry from the previous instruction
		.y(aluResult),
		.condFlags(aluFlags)
	);

	assign wrEn = writeBack & instrValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			psr <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= instrValid;
			if (instrValid) psr <= aluFlags;
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (instrValid) begin
			result <= aluResult;
			resultDst <= dstAddr;
		end
	end

	assign flags = psr; // PSR is already one cycle behind the ALU

	validLowAfterReset: assert property (@(posedge clk) rst |=> !resultValid);

	noLessWhenEqual: assert property (
		@(posedge clk) disable iff (rst)
		!(flags[FLAG_L] && flags[FLAG_Z])
	);

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
	parameter int WIDTH = 16,
	parameter int NUMREGS = 16
) (
	input logic clk,
	input logic rst,
	input logic [15:0] instr,
	input logic instrValid,
	output logic resultValid,
	output logic [WIDTH-1:0] result,
	output logic [cpuPkg::NUM_FLAGS-1:0] flags,
	output logic [$clog2(NUMREGS)-1:0] resultDst
);
	import cpuPkg::*;

	aluOpT aluOp;
	logic [$clog2(NUMREGS)-1:0] srcAddr;
	logic [$clog2(NUMREGS)-1:0] dstAddr;
	logic [WIDTH-1:0] immValue;
	logic useImm;
	logic writeBack;
	logic [WIDTH-1:0] srcData;
	logic [WIDTH-1:0] dstData;
	logic [WIDTH-1:0] aluResult;
	logic wrEn;

	instrDecode #(.WIDTH(WIDTH), .NUMREGS(NUMREGS)) decode (
		.instr(instr), .aluOp(aluOp), .srcAddr(srcAddr), .dstAddr(dstAddr),
		.immValue(immValue), .useImm(useImm), .writeBack(writeBack)
	);

	registerFile #(.WIDTH(WIDTH), .NUMREGS(NUMREGS)) regFile (
		.clk(clk), .rst(rst), .writeEn(wrEn), .writeData(aluResult),
		.srcAddr(srcAddr), .dstAddr(dstAddr),
		.readData1(srcData), .readData2(dstData)
	);

	// destination is operand A, source operand B
	executeStage #(.WIDTH(WIDTH), .NUMREGS(NUMREGS)) execute (
		.clk(clk), .rst(rst), .instrValid(instrValid), .aluOp(aluOp),
		.opA(dstData), .opB(srcData), .immValue(immValue), .useImm(useImm),
		.writeBack(writeBack), .dstAddr(dstAddr), .aluResult(aluResult), .wrEn(wrEn),
		.resultValid(resultValid), .result(result), .flags(flags), .resultDst(resultDst)
	);

endmodule

// ==== test/datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;
	import cpuPkg::*;

	localparam int WIDTH = 16;
	localparam int NUMREGS = 16;
	localparam int NUM_ENTRIES = 35;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;

	logic clk;
	logic rst;
	logic [15:0] instr;
	logic instrValid;
	logic resultValid;
	logic [WIDTH-1:0] result;
	logic [NUM_FLAGS-1:0] flags;
	logic [$clog2(NUMREGS)-1:0] resultDst;

	// four words per entry: instruction, result, flags, check mask
	logic [15:0] golden [NUM_ENTRIES*4];
	logic [15:0] instrMem [NUM_ENTRIES];
	logic [WIDTH-1:0] expResult [NUM_ENTRIES];
	logic [NUM_FLAGS-1:0] expFlags [NUM_ENTRIES];
	logic [1:0] checkMask [NUM_ENTRIES];
	logic [31:0] lfsr;

	datapath dut_i (
		.clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
		.resultValid(resultValid), .result(result), .flags(flags), .resultDst(resultDst)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkValid(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			abortRun($sformatf("error at %0t: resultValid is %b, expected %b (%s)",
				$time, actual, expected, what));
		end
	endtask

	task automatic checkResult(input logic [WIDTH-1:0] actual, input logic [WIDTH-1:0] expected,
			input string what);
		if (actual !== expected) begin
			abortRun($sformatf("error at %0t: result is %h, expected %h (%s)",
				$time, actual, expected, what));
		end
	endtask

	task automatic checkFlags(input logic [NUM_FLAGS-1:0] actual,
			input logic [NUM_FLAGS-1:0] expected, input string what);
		if (actual !== expected) begin
			abortRun($sformatf("error at %0t: flags are %b, expected %b (%s)",
				$time, actual, expected, what));
		end
	endtask

	task automatic checkDst(input logic [$clog2(NUMREGS)-1:0] actual,
			input logic [$clog2(NUMREGS)-1:0] expected, input string what);
		if (actual !== expected) begin
			abortRun($sformatf("error at %0t: resultDst is %0d, expected %0d (%s)",
				$time, actual, expected, what));
		end
	endtask

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic randomGap(output int gap);
		gap = 0;
		repeat (2) begin
			lfsr = lfsrNext(lfsr); // one step per bit
			gap = (gap << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic idleCycle();
		instrValid = 1'b0;
		instr = '0;
		@(posedge clk);
		#DRIVE_DELAY;
		checkValid(resultValid, 1'b0, "idle cycle");
	endtask

	initial begin
		#(CLK_PERIOD * (NUM_ENTRIES * 4 + 20));
		abortRun("simulation timed out before all golden entries were checked");
	end

	initial begin
		int gap;
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		lfsr = 32'hc5676a82;
		$readmemh("test/datapath_golden.txt", golden);
		if ($isunknown(golden[NUM_ENTRIES*4-1])) begin
			abortRun("golden file holds fewer entries than expected");
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			instrMem[i] = golden[4*i];
			expResult[i] = golden[4*i+1];
			expFlags[i] = golden[4*i+2][NUM_FLAGS-1:0];
			checkMask[i] = golden[4*i+3][1:0];
		end

		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		repeat (2) idleCycle(); // nothing issued yet

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			randomGap(gap);
			repeat (gap) idleCycle();
			instr = instrMem[i];
			instrValid = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			// one cycle latency
			checkValid(resultValid, 1'b1, $sformatf("entry %0d", i));
			if (checkMask[i][0]) checkResult(result, expResult[i], $sformatf("entry %0d", i));
			if (checkMask[i][1]) checkFlags(flags, expFlags[i], $sformatf("entry %0d", i));
			checkDst(resultDst, instrMem[i][11:8], $sformatf("entry %0d", i)); // dst field
		end

		// outputs hold the last instruction while idle
		repeat (3) idleCycle();
		checkResult(result, expResult[NUM_ENTRIES-1], "idle hold");
		checkFlags(flags, expFlags[NUM_ENTRIES-1], "idle hold");
		checkDst(resultDst, instrMem[NUM_ENTRIES-1][11:8], "idle hold");
		$display("No errors");
		$finish;
	end

endmodule

// ==== test/datapath_golden.txt ====
// instr result flags mask (hex), flags bits N Z L F C from msb down
// mask bit 0 selects the result check and bit 1 the flags check
01D2 0000 08 3
D134 0034 00 3
F112 1234 00 3
03D1 1234 00 3
D2F0 FFF0 00 3
D40F 000F 00 3
0112 1230 00 3
0422 FFFF 00 3
0434 0000 08 3
05F4 FFFF 00 3
1580 0080 00 3
2581 0081 00 3
3581 0000 08 3
D67F 007F 00 3
F67F 7F7F 00 3
0656 FEFE 02 3
56FF FEFD 01 3
0770 0001 00 3
0796 0104 01 3
9801 FFFF 01 3
F980 8000 00 3
9901 7FFF 02 3
03B1 0000 14 2
02B9 0000 04 2
09B2 0000 10 2
B400 0000 08 2
00D3 1234 00 3
DA04 0004 00 3
830A 2340 00 3
832A 0234 00 3
827A FFFF 00 3
828A FFF0 00 3
897A 07FF 00 3
822A 0FFF 00 3
840A 0000 08 3

// ==== sim.f ====
design/cpuPkg.sv
design/alu.sv
design/registerFile.sv
design/instrDecode.sv
design/executeStage.sv
design/datapath.sv
test/datapathTb.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  - design/cpuPkg.sv
  - design/alu.sv
  - design/registerFile.sv
  - design/instrDecode.sv
  - design/executeStage.sv
  - design/datapath.sv
  - target: test
    files:
      - test/datapathTb.sv
